//--- hdl/fetch_pkg.sv
/*
 * fetch front end package
 * widths, control-flow kinds, fetch states and the packed structs
 * exchanged between the front-end blocks
 */

package fetch_pkg;

	localparam int PC_W   = 64;
	localparam int DATA_W = 64;

	// control-flow class of a fetched instruction
	typedef enum logic [1:0] {
		CTRL_NONE   = 2'd0,
		CTRL_JAL    = 2'd1,
		CTRL_JALR   = 2'd2,
		CTRL_BRANCH = 2'd3
	} ctrl_kind_e;

	// read master states, one read in flight at most
	typedef enum logic [2:0] {
		FS_IDLE = 3'd0,
		FS_ADDR = 3'd1,
		FS_DATA = 3'd2,
		FS_HOLD = 3'd3,
		FS_DROP = 3'd4
	} fetch_state_e;

	typedef struct packed {
		ctrl_kind_e      kind;
		logic            is_rvc;
		logic            is_call;
		logic            is_return;
		// sign extended offset
		logic [PC_W-1:0] imm;
	} predecode_t;

	// one unresolved branch prediction
	typedef struct packed {
		logic            taken;
		logic [PC_W-1:0] alt_pc;
	} pred_entry_t;

	typedef struct packed {
		logic [PC_W-1:0] pc;
		logic [31:0]     instr;
		logic            is_rvc;
	} fetch_out_t;

endpackage

//--- hdl/instr_predecode.sv
/*
 * instruction predecoder
 * spots jal, jalr and conditional branches in both the 32-bit and the
 * compressed encodings, flags call/return hints and builds the offset
 */

`timescale 1ns/1ps

module instr_predecode (
	input  fetch_pkg::fetch_out_t raw,
	output fetch_pkg::predecode_t pd
);

	logic [31:0] ins;
	logic [4:0] rd;
	logic [4:0] rs1;
	logic is_rvc;
	logic i_jal;
	logic i_jalr;
	logic i_branch;
	logic c_j;
	logic c_jr_any;
	logic c_jr;
	logic c_jalr;
	logic c_branch;
	logic link_rd;
	logic link_rs1;
	logic [fetch_pkg::PC_W-1:0] i_imm;
	logic [fetch_pkg::PC_W-1:0] c_imm;

	assign ins = raw.instr;
	assign is_rvc = raw.is_rvc;
	assign rd = ins[11:7];
	assign rs1 = ins[19:15];

	// x1 and x5 are the link registers
	assign link_rd = (rd == 5'd1) | (rd == 5'd5);
	assign link_rs1 = (rs1 == 5'd1) | (rs1 == 5'd5);

	assign i_jal = ~is_rvc & (ins[6:0] == 7'b1101111);
	assign i_jalr = ~is_rvc & (ins[6:0] == 7'b1100111);
	assign i_branch = ~is_rvc & (ins[6:0] == 7'b1100011);

	// quadrant 1, funct3 101 is the compressed jump
	assign c_j = is_rvc & (ins[1:0] == 2'b01) & (ins[15:13] == 3'b101);
	// c.jr / c.jalr need rs2 = 0 and rs1 != 0, otherwise c.mv / c.add
	assign c_jr_any = is_rvc & (ins[1:0] == 2'b10) & (ins[15:13] == 3'b100)
		& (ins[6:2] == 5'd0) & (rd != 5'd0);
	assign c_jr = c_jr_any & ~ins[12];
	assign c_jalr = c_jr_any & ins[12];
	assign c_branch = is_rvc & (ins[1:0] == 2'b01) & (ins[15:14] == 2'b11);

	always_comb begin
		i_imm = '0;
		if (i_jal) begin
			i_imm = {{(fetch_pkg::PC_W-20){ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		end else if (i_jalr) begin
			i_imm = {{(fetch_pkg::PC_W-12){ins[31]}}, ins[31:20]};
		end else if (i_branch) begin
			i_imm = {{(fetch_pkg::PC_W-12){ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		end
	end

	always_comb begin
		c_imm = '0;
		if (c_j) begin
			c_imm = {{(fetch_pkg::PC_W-12){ins[12]}}, ins[12], ins[8], ins[10:9], ins[6],
				ins[7], ins[2], ins[11], ins[5:3], 1'b0};
		end else if (c_branch) begin
			c_imm = {{(fetch_pkg::PC_W-9){ins[12]}}, ins[12], ins[6:5], ins[2],
				ins[11:10], ins[4:3], 1'b0};
		end
	end

	always_comb begin
		pd.kind = fetch_pkg::CTRL_NONE;
		if (i_jal | c_j) begin
			pd.kind = fetch_pkg::CTRL_JAL;
		end else if (i_jalr | c_jr_any) begin
			pd.kind = fetch_pkg::CTRL_JALR;
		end else if (i_branch | c_branch) begin
			pd.kind = fetch_pkg::CTRL_BRANCH;
		end
		pd.is_rvc = is_rvc;
		// c.jalr always links x1
		pd.is_call = ((i_jal | i_jalr) & link_rd) | c_jalr;
		pd.is_return = (i_jalr & link_rs1 & (rs1 != rd)) | (c_jr & link_rd);
		pd.imm = is_rvc ? c_imm : i_imm;
	end

endmodule

//--- hdl/return_stack.sv
/*
 * return address stack
 * circular, a push when full overwrites the oldest entry
 */

`timescale 1ns/1ps

module return_stack #(
	parameter int RAS_AW = 4
) (
	input  logic                       CLK,
	input  logic                       rst,
	input  logic                       flush,
	input  logic                       push,
	input  logic                       pop,
	input  logic [fetch_pkg::PC_W-1:0] push_addr,
	output logic [fetch_pkg::PC_W-1:0] pop_addr,
	output logic                       empty
);

	localparam int DEPTH = 2 ** RAS_AW;

	logic [fetch_pkg::PC_W-1:0] mem [DEPTH];
	// next free slot, top of stack sits one below
	logic [RAS_AW-1:0] top_ptr;
	logic [RAS_AW-1:0] top_idx;
	logic [RAS_AW-1:0] wr_idx;
	logic [RAS_AW:0] count;
	logic do_pop;

	assign empty = (count == '0);
	assign do_pop = pop & ~empty;
	assign top_idx = top_ptr - 1'b1;
	// push together with pop replaces the top
	assign wr_idx = do_pop ? top_idx : top_ptr;
	assign pop_addr = mem[top_idx];

	always_ff @(posedge CLK) begin
		if (rst | flush) begin
			top_ptr <= '0;
			count <= '0;
		end else if (push & ~do_pop) begin
			top_ptr <= top_ptr + 1'b1;
			if (count != (RAS_AW+1)'(DEPTH)) begin
				count <= count + 1'b1;
			end
		end else if (do_pop & ~push) begin
			top_ptr <= top_idx;
			count <= count - 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (push) begin
			mem[wr_idx] <= push_addr;
		end
	end

endmodule

//--- hdl/resolve_fifo.sv
/*
 * resolve FIFO
 * branch predictions in fetch order, retired one by one as the
 * branch unit reports each outcome
 */

`timescale 1ns/1ps

module resolve_fifo #(
	parameter int RES_AW = 4
) (
	input  logic                   CLK,
	input  logic                   rst,
	input  logic                   flush,
	input  logic                   push,
	input  logic                   pop,
	input  fetch_pkg::pred_entry_t push_entry,
	output fetch_pkg::pred_entry_t head_entry,
	output logic                   empty,
	output logic                   full
);

	localparam int DEPTH = 2 ** RES_AW;

	fetch_pkg::pred_entry_t mem [DEPTH];
	logic [RES_AW-1:0] rd_ptr;
	logic [RES_AW-1:0] wr_ptr;
	logic [RES_AW:0] count;
	logic do_push;
	logic do_pop;

	assign empty = (count == '0);
	assign full = (count == (RES_AW+1)'(DEPTH));
	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;
	assign head_entry = mem[rd_ptr];

	always_ff @(posedge CLK) begin
		if (rst | flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (do_push & ~do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop & ~do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (do_push) begin
			mem[wr_ptr] <= push_entry;
		end
	end

endmodule

//--- hdl/pc_generate.sv
/*
 * PC generation
 * static prediction on the predecoded word, redirect priority
 * exception > mispredict > grant > hold, and the queue handshake
 */

`timescale 1ns/1ps

module pc_generate #(
	parameter logic [fetch_pkg::PC_W-1:0] RESET_PC = 64'h8000_0000
) (
	input  logic                       CLK,
	input  logic                       rst,
	input  logic                       raw_valid,
	input  fetch_pkg::fetch_out_t      raw,
	input  fetch_pkg::predecode_t      pd,
	output logic                       ras_push,
	output logic                       ras_pop,
	output logic [fetch_pkg::PC_W-1:0] ras_push_addr,
	input  logic [fetch_pkg::PC_W-1:0] ras_pop_addr,
	input  logic                       ras_empty,
	output logic                       res_push,
	output logic                       res_pop,
	output fetch_pkg::pred_entry_t     res_push_entry,
	input  fetch_pkg::pred_entry_t     res_head_entry,
	input  logic                       res_empty,
	input  logic                       res_full,
	input  logic                       bru_valid,
	input  logic                       bru_taken,
	input  logic                       jalr_valid,
	input  logic [fetch_pkg::PC_W-1:0] jalr_pc,
	input  logic                       excp_valid,
	input  logic [fetch_pkg::PC_W-1:0] excp_pc,
	input  logic                       instr_ready,
	output logic                       instr_valid,
	output fetch_pkg::fetch_out_t      instr_out,
	output logic                       consume,
	output logic                       kill,
	output logic                       flush,
	output logic [fetch_pkg::PC_W-1:0] pc
);

	logic [fetch_pkg::PC_W-1:0] pc_q;
	logic [fetch_pkg::PC_W-1:0] seq_pc;
	logic [fetch_pkg::PC_W-1:0] target_pc;
	logic [fetch_pkg::PC_W-1:0] next_pc;
	logic is_jal;
	logic is_jalr;
	logic is_branch;
	logic use_ras;
	logic taken;
	logic stall;
	logic mispredict;
	logic grant;

	assign is_jal = (pd.kind == fetch_pkg::CTRL_JAL);
	assign is_jalr = (pd.kind == fetch_pkg::CTRL_JALR);
	assign is_branch = (pd.kind == fetch_pkg::CTRL_BRANCH);
	assign use_ras = is_jalr & pd.is_return & ~ras_empty;

	assign seq_pc = pc_q + (pd.is_rvc ? 64'd2 : 64'd4);

	always_comb begin
		if (is_jal | is_branch) begin
			target_pc = pc_q + pd.imm;
		end else if (use_ras) begin
			target_pc = ras_pop_addr;
		end else begin
			target_pc = jalr_pc;
		end
	end

	// jumps always taken, branches only when going backward
	assign taken = is_jal | is_jalr | (is_branch & pd.imm[fetch_pkg::PC_W-1]);
	assign next_pc = taken ? target_pc : seq_pc;

	assign stall = (is_branch & res_full) | (is_jalr & ~use_ras & ~jalr_valid);

	assign mispredict = bru_valid & ~res_empty & (bru_taken != res_head_entry.taken);
	assign flush = excp_valid | mispredict;
	assign kill = flush;

	assign instr_valid = raw_valid & ~stall & ~flush;
	assign instr_out = raw;
	assign grant = instr_valid & instr_ready;
	assign consume = grant;

	assign ras_push = grant & pd.is_call;
	assign ras_pop = grant & use_ras;
	assign ras_push_addr = seq_pc;

	// keep the path not predicted for the branch unit check
	assign res_push = grant & is_branch;
	assign res_push_entry.taken = taken;
	assign res_push_entry.alt_pc = taken ? seq_pc : target_pc;
	assign res_pop = bru_valid & ~res_empty;

	always_ff @(posedge CLK) begin
		if (rst) begin
			pc_q <= RESET_PC;
		end else if (excp_valid) begin
			pc_q <= excp_pc;
		end else if (mispredict) begin
			pc_q <= res_head_entry.alt_pc;
		end else if (grant) begin
			pc_q <= next_pc;
		end
	end

	assign pc = pc_q;

endmodule

//--- hdl/fetch_unit.sv
/*
 * instruction fetch read master
 * AXI4-Lite reads at the fetch PC, aligns the 32-bit window and holds
 * the word until it is consumed or killed
 */

`timescale 1ns/1ps

module fetch_unit (
	input  logic                         CLK,
	input  logic                         rst,
	input  logic [fetch_pkg::PC_W-1:0]   pc,
	input  logic                         kill,
	input  logic                         consume,
	output logic [fetch_pkg::PC_W-1:0]   araddr,
	output logic                         arvalid,
	input  logic                         arready,
	input  logic [fetch_pkg::DATA_W-1:0] rdata,
	input  logic                         rvalid,
	output logic                         rready,
	output logic                         raw_valid,
	output fetch_pkg::fetch_out_t        raw
);

	fetch_pkg::fetch_state_e state;
	fetch_pkg::fetch_out_t raw_q;
	logic [fetch_pkg::PC_W-1:0] fetch_pc;
	// kill seen while the address was still waiting for arready
	logic killed;
	logic [31:0] sel;

	// halfword aligned pc picks the upper window
	assign sel = fetch_pc[1] ? rdata[47:16] : rdata[31:0];

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= fetch_pkg::FS_IDLE;
			killed <= 1'b0;
		end else begin
			case (state)
				fetch_pkg::FS_IDLE: begin
					if (!kill) begin
						state <= fetch_pkg::FS_ADDR;
					end
				end
				fetch_pkg::FS_ADDR: begin
					if (arready) begin
						state <= (kill | killed) ? fetch_pkg::FS_DROP : fetch_pkg::FS_DATA;
						killed <= 1'b0;
					end else if (kill) begin
						killed <= 1'b1;
					end
				end
				fetch_pkg::FS_DATA: begin
					if (rvalid) begin
						state <= kill ? fetch_pkg::FS_IDLE : fetch_pkg::FS_HOLD;
					end else if (kill) begin
						state <= fetch_pkg::FS_DROP;
					end
				end
				fetch_pkg::FS_HOLD: begin
					if (kill | consume) begin
						state <= fetch_pkg::FS_IDLE;
					end
				end
				fetch_pkg::FS_DROP: begin
					if (rvalid) begin
						state <= fetch_pkg::FS_IDLE;
					end
				end
				default: state <= fetch_pkg::FS_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == fetch_pkg::FS_IDLE) begin
			fetch_pc <= pc;
		end
		if ((state == fetch_pkg::FS_DATA) && rvalid) begin
			raw_q.pc <= fetch_pc;
			raw_q.instr <= sel;
			raw_q.is_rvc <= (sel[1:0] != 2'b11);
		end
	end

	assign araddr = {fetch_pc[fetch_pkg::PC_W-1:2], 2'b00};
	assign arvalid = (state == fetch_pkg::FS_ADDR);
	assign rready = (state == fetch_pkg::FS_DATA) | (state == fetch_pkg::FS_DROP);
	assign raw_valid = (state == fetch_pkg::FS_HOLD);
	assign raw = raw_q;

endmodule

//--- hdl/frontend_top.sv
/*
 * fetch front end top level
 * read master, predecoder, return stack, resolve FIFO and PC generation
 */

`timescale 1ns/1ps

module frontend_top #(
	parameter logic [fetch_pkg::PC_W-1:0] RESET_PC = 64'h8000_0000,
	parameter int RAS_AW = 4,
	parameter int RES_AW = 4
) (
	input  logic                         CLK,
	input  logic                         rst,
	output logic [fetch_pkg::PC_W-1:0]   araddr,
	output logic                         arvalid,
	input  logic                         arready,
	input  logic [fetch_pkg::DATA_W-1:0] rdata,
	input  logic                         rvalid,
	output logic                         rready,
	output fetch_pkg::fetch_out_t        instr_out,
	output logic                         instr_valid,
	input  logic                         instr_ready,
	input  logic                         bru_valid,
	input  logic                         bru_taken,
	input  logic                         jalr_valid,
	input  logic [fetch_pkg::PC_W-1:0]   jalr_pc,
	input  logic                         excp_valid,
	input  logic [fetch_pkg::PC_W-1:0]   excp_pc,
	output logic                         flush
);

	fetch_pkg::fetch_out_t raw;
	fetch_pkg::predecode_t pd;
	fetch_pkg::pred_entry_t res_push_entry;
	fetch_pkg::pred_entry_t res_head_entry;
	logic [fetch_pkg::PC_W-1:0] pc;
	logic [fetch_pkg::PC_W-1:0] ras_push_addr;
	logic [fetch_pkg::PC_W-1:0] ras_pop_addr;
	logic raw_valid;
	logic consume;
	logic kill;
	logic ras_push;
	logic ras_pop;
	logic ras_empty;
	logic res_push;
	logic res_pop;
	logic res_empty;
	logic res_full;

	fetch_unit i_fetch_unit (
		.CLK(CLK), .rst(rst), .pc(pc), .kill(kill), .consume(consume),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rvalid(rvalid), .rready(rready),
		.raw_valid(raw_valid), .raw(raw)
	);

	instr_predecode i_predecode (.raw(raw), .pd(pd));

	return_stack #(.RAS_AW(RAS_AW)) i_ras (
		.CLK(CLK), .rst(rst), .flush(flush), .push(ras_push), .pop(ras_pop),
		.push_addr(ras_push_addr), .pop_addr(ras_pop_addr), .empty(ras_empty)
	);

	resolve_fifo #(.RES_AW(RES_AW)) i_resolve (
		.CLK(CLK), .rst(rst), .flush(flush), .push(res_push), .pop(res_pop),
		.push_entry(res_push_entry), .head_entry(res_head_entry),
		.empty(res_empty), .full(res_full)
	);

	pc_generate #(.RESET_PC(RESET_PC)) i_pc_generate (
		.CLK(CLK), .rst(rst), .raw_valid(raw_valid), .raw(raw), .pd(pd),
		.ras_push(ras_push), .ras_pop(ras_pop), .ras_push_addr(ras_push_addr),
		.ras_pop_addr(ras_pop_addr), .ras_empty(ras_empty),
		.res_push(res_push), .res_pop(res_pop), .res_push_entry(res_push_entry),
		.res_head_entry(res_head_entry), .res_empty(res_empty), .res_full(res_full),
		.bru_valid(bru_valid), .bru_taken(bru_taken),
		.jalr_valid(jalr_valid), .jalr_pc(jalr_pc),
		.excp_valid(excp_valid), .excp_pc(excp_pc),
		.instr_ready(instr_ready), .instr_valid(instr_valid), .instr_out(instr_out),
		.consume(consume), .kill(kill), .flush(flush), .pc(pc)
	);

endmodule

//--- testbench/fetch_checker.sv
/*
 * fetch front end checker
 * reference model of the predicted instruction stream, compared with the
 * instruction queue, redirect and AXI4-Lite read ports of the DUT
 */

`timescale 1ns/1ps

module fetch_checker #(
	parameter logic [63:0] RESET_PC = 64'h8000_0000,
	parameter int IMG_BYTES = 512
) (
	input  logic                  CLK,
	input  logic                  rst,
	input  fetch_pkg::fetch_out_t instr_out,
	input  logic                  instr_valid,
	input  logic                  instr_ready,
	input  logic [63:0]           araddr,
	input  logic                  arvalid,
	input  logic                  arready,
	input  logic                  rvalid,
	input  logic                  rready,
	input  logic                  bru_valid,
	input  logic                  bru_taken,
	input  logic [63:0]           jalr_pc,
	input  logic                  excp_valid,
	input  logic [63:0]           excp_pc,
	input  logic                  flush
);

	int value_errors = 0;
	int proto_errors = 0;
	logic [63:0] expect_pc;
	logic [63:0] ras_q [$];
	// {predicted taken, alternative pc}
	logic [64:0] pred_q [$];
	fetch_pkg::fetch_out_t held_out;
	logic held = 1'b0;
	logic ar_wait = 1'b0;
	logic [63:0] ar_prev;
	logic stale = 1'b0;
	int outstanding = 0;

	task automatic value_fail(input string msg);
		value_errors++;
		$display("FAIL %0d ns: %s", $time, msg);
	endtask

	task automatic proto_fail(input string msg);
		proto_errors++;
		$display("protocol error at %0d ns: %s", $time, msg);
	endtask

	function automatic logic [31:0] img_word(input logic [63:0] a);
		int i;
		i = int'((a - RESET_PC) & 64'(IMG_BYTES - 1));
		return {tb_frontend.mem[(i + 3) % IMG_BYTES], tb_frontend.mem[(i + 2) % IMG_BYTES],
			tb_frontend.mem[(i + 1) % IMG_BYTES], tb_frontend.mem[i]};
	endfunction

	function automatic logic [63:0] jal_off(input logic [31:0] w);
		return {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
	endfunction

	function automatic logic [63:0] br_off(input logic [31:0] w);
		return {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
	endfunction

	function automatic logic is_link(input logic [4:0] r);
		return (r == 5'd1) || (r == 5'd5);
	endfunction

	function automatic logic is_jalr(input logic [31:0] w);
		if (w[1:0] == 2'b11)
			return w[6:0] == 7'b1100111;
		return (w[1:0] == 2'b10) && (w[15:13] == 3'b100) && (w[6:2] == 0) && (w[11:7] != 0);
	endfunction

	function automatic logic is_ret(input logic [31:0] w);
		if (w[1:0] == 2'b11)
			return is_jalr(w) && is_link(w[19:15]) && (w[19:15] != w[11:7]);
		return is_jalr(w) && !w[12] && is_link(w[11:7]);
	endfunction

	function automatic logic is_call(input logic [31:0] w);
		if (w[1:0] == 2'b11)
			return (is_jalr(w) || (w[6:0] == 7'b1101111)) && is_link(w[11:7]);
		return is_jalr(w) && w[12];
	endfunction

	// expected pc after a granted instruction
	function automatic logic [63:0] ref_next(input logic [63:0] pc, input logic [31:0] w);
		logic [63:0] seq;
		logic [63:0] off;
		seq = pc + ((w[1:0] != 2'b11) ? 64'd2 : 64'd4);
		off = br_off(w);
		if (w[1:0] == 2'b11 && w[6:0] == 7'b1101111)
			return pc + jal_off(w);
		if (w[1:0] == 2'b11 && w[6:0] == 7'b1100011)
			return off[63] ? pc + off : seq;
		if (is_jalr(w))
			return (is_ret(w) && ras_q.size() > 0) ? ras_q[$] : jalr_pc;
		return seq;
	endfunction

	always @(negedge CLK) begin
		logic mis;
		logic [31:0] w;
		logic [63:0] p;
		logic [63:0] seq;
		logic [63:0] off;
		if (rst) begin
			expect_pc = RESET_PC;
			ras_q.delete();
			pred_q.delete();
		end else begin
			mis = bru_valid && pred_q.size() > 0 && (bru_taken != pred_q[0][64]);
			if (flush !== (excp_valid || mis))
				value_fail($sformatf("flush is %b, expected %b", flush, excp_valid || mis));
			if (held && !flush && (!instr_valid || instr_out !== held_out))
				proto_fail("instruction changed or vanished while instr_ready was low");
			if (ar_wait && !(arvalid && araddr == ar_prev))
				proto_fail("read address dropped or changed before arready");
			if (rready !== (outstanding != 0))
				proto_fail($sformatf("rready is %b with %0d reads outstanding",
					rready, outstanding));
			if (arvalid && arready) begin
				if (outstanding != 0)
					proto_fail("second read issued while one is outstanding");
				outstanding++;
				if (!stale && !flush && araddr != {expect_pc[63:2], 2'b00})
					value_fail($sformatf("araddr %h, expected %h", araddr, expect_pc));
				stale = 1'b0;
			end else if (flush && arvalid) begin
				stale = 1'b1;
			end
			if (rvalid && rready)
				outstanding--;
			if (flush) begin
				expect_pc = excp_valid ? excp_pc : pred_q[0][63:0];
				pred_q.delete();
				ras_q.delete();
			end else begin
				if (bru_valid && pred_q.size() > 0)
					void'(pred_q.pop_front());
				if (instr_valid && instr_ready) begin
					p = instr_out.pc;
					w = instr_out.instr;
					seq = p + ((w[1:0] != 2'b11) ? 64'd2 : 64'd4);
					off = br_off(w);
					if (p != expect_pc)
						value_fail($sformatf("granted pc %h, expected %h", p, expect_pc));
					if (w != img_word(p) || instr_out.is_rvc != (w[1:0] != 2'b11))
						value_fail($sformatf("instruction %h at %h, image holds %h",
							w, p, img_word(p)));
					expect_pc = ref_next(p, w);
					if (w[1:0] == 2'b11 && w[6:0] == 7'b1100011)
						pred_q.push_back({off[63], off[63] ? seq : p + off});
					if (is_ret(w) && ras_q.size() > 0)
						void'(ras_q.pop_back());
					if (is_call(w)) begin
						ras_q.push_back(seq);
						// oldest entry overwritten beyond 16
						if (ras_q.size() > 16)
							void'(ras_q.pop_front());
					end
				end
			end
		end
		held = !rst && instr_valid && !instr_ready && !flush;
		held_out = instr_out;
		ar_wait = !rst && arvalid && !arready;
		ar_prev = araddr;
	end

endmodule

//--- testbench/tb_frontend.sv
/*
 * fetch front end testbench
 * program image with an AXI4-Lite memory model, random back-pressure,
 * branch unit results, jalr targets and exceptions
 */

`timescale 1ns/1ps

module tb_frontend;

	localparam logic [63:0] BASE = 64'h8000_0000;
	localparam int IMG_BYTES = 512;
	localparam int N_INSTR = 200;
	localparam logic [63:0] LOOP_BR = BASE + 64'h14;
	localparam logic [63:0] FWD_BR = BASE + 64'h18;
	localparam logic [63:0] HANDLER = BASE + 64'h40;

	logic [7:0] mem [IMG_BYTES];
	logic CLK = 1'b0;
	logic rst;
	logic [63:0] araddr;
	logic arvalid;
	logic arready;
	logic [63:0] rdata;
	logic rvalid;
	logic rready;
	fetch_pkg::fetch_out_t instr_out;
	logic instr_valid;
	logic instr_ready;
	logic bru_valid;
	logic bru_taken;
	logic jalr_valid;
	logic [63:0] jalr_pc;
	logic excp_valid;
	logic [63:0] excp_pc;
	logic flush;

	int pos;
	int grants = 0;
	int loop_cnt = 0;
	int fwd_cnt = 0;
	int n_mis = 0;
	int rd_cnt;
	logic rd_busy = 1'b0;
	logic r_done;
	logic excp_done = 1'b0;
	logic [63:0] rd_addr;
	// granted branches waiting for a result
	logic [63:0] pend [$];

	frontend_top #(.RESET_PC(BASE)) i_dut (.*);

	fetch_checker #(.RESET_PC(BASE), .IMG_BYTES(IMG_BYTES)) i_chk (.*);

	always #10 CLK = ~CLK;

	task automatic put16(input logic [15:0] h);
		mem[pos] = h[7:0];
		mem[pos + 1] = h[15:8];
		pos += 2;
	endtask

	task automatic put32(input logic [31:0] w);
		put16(w[15:0]);
		put16(w[31:16]);
	endtask

	function automatic logic [31:0] alu32();
		return {12'($urandom % 2048), 5'd0, 3'b000, 5'($urandom % 31 + 1), 7'b0010011};
	endfunction

	// c.addi with a nonzero register
	function automatic logic [15:0] alu16();
		return {4'b0000, 5'($urandom % 31 + 1), 5'd1, 2'b01};
	endfunction

	function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [12:0] off);
		return {off[12], off[10:5], 5'd0, 5'd0, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	task automatic build_image();
		logic [63:0] a;
		for (int i = 0; i < IMG_BYTES / 4; i++) begin
			a = BASE + 64'(4 * i);
			pos = 4 * i;
			put32({a[13:2] ^ a[31:20], 5'd0, 3'b000, 5'd10, 7'b0010011});
		end
		pos = 0;
		put32(alu32());
		put16(alu16());
		put32(enc_jal(5'd1, 21'h17a));
		put32(alu32());
		put16(alu16());
		put32(alu32());
		put32(enc_b(3'b000, 13'(-6)));
		put32(enc_b(3'b001, 13'd8));
		put32(alu32());
		// jalr x0, 0(x6), not a return
		put32(32'h0003_0067);
		pos = 'h40;
		put32(alu32());
		put32(enc_jal(5'd0, 21'(-68)));
		pos = 'h60;
		put32(alu32());
		put16(alu16());
		put32(enc_jal(5'd0, 21'(-102)));
		pos = 'h180;
		put32(alu32());
		put16(alu16());
		put16(16'h8082);
	endtask

	function automatic logic [63:0] read64(input logic [63:0] a);
		logic [63:0] d;
		int i;
		i = int'((a - BASE) & 64'(IMG_BYTES - 1));
		for (int k = 0; k < 8; k++)
			d[8 * k +: 8] = mem[(i + k) % IMG_BYTES];
		return d;
	endfunction

	task automatic decide_outcome(input logic [63:0] p, output logic tk);
		tk = 1'b0;
		if (p == LOOP_BR) begin
			// four passes, the last falls through
			tk = (loop_cnt % 4) != 3;
			loop_cnt++;
		end else if (p == FWD_BR) begin
			tk = (fwd_cnt % 2) == 0;
			fwd_cnt++;
		end
	endtask

	// handshakes seen in this cycle
	always @(negedge CLK) begin
		r_done = rvalid && rready;
		if (!rst) begin
			if (bru_valid && pend.size() > 0)
				void'(pend.pop_front());
			if (flush) begin
				pend.delete();
			end else if (instr_valid && instr_ready) begin
				grants++;
				if (!instr_out.is_rvc && instr_out.instr[6:0] == 7'b1100011)
					pend.push_back(instr_out.pc);
			end
			if (arvalid && arready) begin
				rd_addr = araddr;
				rd_cnt = $urandom % 4;
				rd_busy = 1'b1;
			end
		end
	end

	always @(posedge CLK) begin
		logic tk;
		#2;
		arready = ($urandom % 2) == 1;
		instr_ready = ($urandom % 4) != 0;
		if (r_done) begin
			rvalid = 1'b0;
			rd_busy = 1'b0;
		end else if (rd_busy && !rvalid) begin
			if (rd_cnt == 0) begin
				rvalid = 1'b1;
				rdata = read64(rd_addr);
			end else begin
				rd_cnt--;
			end
		end
		bru_valid = 1'b0;
		excp_valid = 1'b0;
		if (!rst && pend.size() > 0 && ($urandom % 2) == 1) begin
			decide_outcome(pend[0], tk);
			bru_valid = 1'b1;
			bru_taken = tk;
			if (tk != (pend[0] == LOOP_BR)) begin
				n_mis++;
				// exception on top of a mispredict
				if (n_mis == 3) begin
					excp_valid = 1'b1;
					excp_pc = HANDLER;
				end
			end
		end
		if (grants >= 70 && !excp_done) begin
			excp_valid = 1'b1;
			excp_pc = HANDLER;
			excp_done = 1'b1;
		end
	end

	initial begin
		void'($urandom(28));
		rst = 1'b1;
		arready = 1'b0;
		rdata = '0;
		rvalid = 1'b0;
		instr_ready = 1'b0;
		bru_valid = 1'b0;
		bru_taken = 1'b0;
		jalr_valid = 1'b1;
		jalr_pc = BASE + 64'h60;
		excp_valid = 1'b0;
		excp_pc = '0;
		build_image();
		repeat (2) @(posedge CLK);
		#2 rst = 1'b0;
		wait (grants >= N_INSTR);
		repeat (2) @(posedge CLK);
		$display("errors: %0d value, %0d protocol", i_chk.value_errors, i_chk.proto_errors);
		if (i_chk.value_errors == 0 && i_chk.proto_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin
		#(N_INSTR * 40 * 20);
		$display("timeout: only %0d of %0d instructions granted", grants, N_INSTR);
		$display("errors: %0d value, %0d protocol", i_chk.value_errors, i_chk.proto_errors);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- src.f
hdl/fetch_pkg.sv
hdl/instr_predecode.sv
hdl/return_stack.sv
hdl/resolve_fifo.sv
hdl/pc_generate.sv
hdl/fetch_unit.sv
hdl/frontend_top.sv
testbench/fetch_checker.sv
testbench/tb_frontend.sv

//--- run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary -f src.f --top-module tb_frontend -o Vtb_frontend \
	&& ./obj_dir/Vtb_frontend | tee /dev/stderr | grep -q "SIMULATION PASSED" \
	&& echo "run ok" \
	|| { echo "run failed"; exit 1; }
